// File: dv/core_checker.sv
`timescale 1ns/1ps

module core_checker import isa_pkg::*, pipe_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      instr_req,
  input logic      wb_cyc,
  input logic      wb_stb,
  input logic      wb_stall,
  input word_t     wb_addr,
  input word_t     wb_wr_data,
  input byte_sel_t wb_wr_sel,
  input logic      stall,         // global stall, decode holds
  input reg_addr_t rs2,           // decode read port 2
  input word_t     dec_rs2_data   // registered operand toward execute
);

  // strobe only inside a bus cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
    else $error("wb_stb high without wb_cyc");

  // request fields frozen while the slave stalls
  a_stb_stable: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && wb_stall |=> $stable(wb_addr) && $stable(wb_wr_data) && $stable(wb_wr_sel))
    else $error("store request changed while stalled");

  // nothing fetched while held in reset
  a_no_req_in_reset: assert property (@(posedge clk) !rst_n |=> !instr_req)
    else $error("instr_req raised during reset");

  // an x0 operand lands in the decode register as zero
  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    rs2 == '0 && !stall |=> dec_rs2_data == '0)
    else $error("x0 read back non-zero");

endmodule

bind core core_checker chk0 (
  .clk, .rst_n, .instr_req, .wb_cyc, .wb_stb, .wb_stall, .wb_addr, .wb_wr_data, .wb_wr_sel,
  .stall, .dec_rs2_data,
  .rs2(decode0.rs2)
);

// File: dv/core_stim.txt
// word 0: program length, word 1: number of expected stores
// then program words, then one store per line as address, data, byte select
00000032 00000012
10000093 FF900113 00300193 00310233 0040A023 402182B3 0050A223 00312333
0060A423 403153B3 00315433 003194B3 0070A623 0080A823 0090AA23 0F014513
00656593 7FF5F613 00C0AC23 00419693 40115713 FFA12793 00E68833 00F80833
0100AE23 00518013 0200A023 ABCDE8B7 0310A223 00C0096F 0230A423 0230A623
0320A423 00318663 0230A623 0230A823 00319463 0230A623 00311663 0220A823
0220A823 12345A37 678A0A13 03408823 034088A3 03408923 034089A3 03409A23
03409B23 0000006F
00000100 FFFFFFFC 0000000F
00000104 0000000A 0000000F
00000108 00000001 0000000F
0000010C FFFFFFFF 0000000F
00000110 1FFFFFFF 0000000F
00000114 00000018 0000000F
00000118 0000070F 0000000F
0000011C 0000002D 0000000F
00000120 00000000 0000000F
00000124 ABCDE000 0000000F
00000128 00000078 0000000F
0000012C 00000003 0000000F
00000130 78787878 00000001
00000131 78787878 00000002
00000132 78787878 00000004
00000133 78787878 00000008
00000134 56785678 00000003
00000136 56785678 0000000C

// File: dv/core_tb.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core_tb import isa_pkg::*, pipe_pkg::*;;

  logic      clk;
  logic      rst_n;
  word_t     instr_addr;
  word_t     instr;
  logic      instr_req;
  logic      instr_ack;
  logic      wb_cyc;
  logic      wb_stb;
  word_t     wb_addr;
  word_t     wb_wr_data;
  byte_sel_t wb_wr_sel;
  logic      wb_ack;
  logic      wb_stall;

  logic [31:0] stim [0:1023];  // counts, program, then addr/data/sel triples
  int n_prog;
  int n_st;
  int seen;          // stores accepted so far
  int passed;
  int failed;
  int cycles;
  int limit;
  int icnt;
  int scnt;
  int acnt;
  int sstate;
  bit iactive;
  bit first_seen;

  core dut0 (.*);

  always #50 clk = ~clk;

  function automatic word_t prog_word(input word_t addr);
    if (addr[31:2] < n_prog)
      return stim[2 + addr[31:2]];
    return `CORE_NOP;  // past the program end
  endfunction

  // compare one accepted store with the next expected triple
  task automatic check_store();
    int errs;
    int base;
    errs = 0;
    base = 2 + n_prog + 3 * seen;
    assert (seen < n_st) else begin
      $display("unexpected extra store to %h at %0t", wb_addr, $time);
      errs++;
    end
    if (seen < n_st) begin
      assert (wb_addr == stim[base]) else begin
        $display("Mismatch at %0t: wb_addr expected %h got %h", $time, stim[base], wb_addr);
        errs++;
      end
      assert (wb_wr_data == stim[base+1]) else begin
        $display("Mismatch at %0t: wb_wr_data expected %h got %h", $time, stim[base+1],
                 wb_wr_data);
        errs++;
      end
      assert (wb_wr_sel == byte_sel_t'(stim[base+2])) else begin
        $display("Mismatch at %0t: wb_wr_sel expected %h got %h", $time,
                 byte_sel_t'(stim[base+2]), wb_wr_sel);
        errs++;
      end
    end
    $display("store %0d to %h: %s", seen, wb_addr, errs == 0 ? "ok" : "failed");
    if (errs == 0) passed++;
    else failed++;
    seen++;
  endtask

  // instruction memory, 0..3 cycles per answer
  always @(negedge clk) begin
    if (!rst_n) begin
      instr_ack = 1'b0;
      iactive   = 1'b0;
    end else if (instr_ack) begin
      instr_ack = 1'b0;  // one-cycle ack
      iactive   = 1'b0;
    end else if (instr_req) begin
      if (!first_seen) begin
        first_seen = 1'b1;
        assert (instr_addr == `CORE_PC_RESET) else begin
          $display("Mismatch at %0t: instr_addr expected %h got %h", $time,
                   `CORE_PC_RESET, instr_addr);
          failed++;
        end
        if (instr_addr == `CORE_PC_RESET) passed++;
        $display("reset fetch address %h", instr_addr);
      end
      if (!iactive) begin
        iactive = 1'b1;
        icnt    = $urandom % 4;
      end
      if (icnt == 0) begin
        instr     = prog_word(instr_addr);
        instr_ack = 1'b1;
      end else begin
        icnt--;
      end
    end
  end

  // data memory: 0..2 stall cycles, ack 1..3 cycles after accept
  always @(negedge clk) begin
    if (!rst_n) begin
      wb_stall = 1'b0;
      wb_ack   = 1'b0;
      sstate   = 0;
    end else begin
      wb_ack = 1'b0;
      case (sstate)
        0: if (wb_stb) begin
          scnt     = $urandom % 3;
          wb_stall = scnt != 0;
          sstate   = 1;
        end
        1: if (scnt > 0) begin
          scnt--;
          wb_stall = scnt != 0;
        end
        default: ;
      endcase
      if (sstate == 1 && !wb_stall) begin
        check_store();  // taken at the coming edge
        acnt   = 1 + $urandom % 3;
        sstate = 2;
      end else if (sstate == 2) begin
        // accepted, strobe gone and cycle held until the ack
        assert (wb_cyc) else begin
          $display("Mismatch at %0t: wb_cyc expected 1 got %b", $time, wb_cyc);
          failed++;
        end
        assert (!wb_stb) else begin
          $display("Mismatch at %0t: wb_stb expected 0 got %b", $time, wb_stb);
          failed++;
        end
        acnt--;
        if (acnt == 0) begin
          wb_ack = 1'b1;
          sstate = 3;
        end
      end else if (sstate == 3) begin
        assert (!wb_cyc) else begin  // cycle closed by the ack
          $display("Mismatch at %0t: wb_cyc expected 0 got %b", $time, wb_cyc);
          failed++;
        end
        sstate = 0;
      end
    end
  end

  initial begin
    void'($urandom(32'h95a9));
    clk        = 1'b0;
    rst_n      = 1'b0;
    instr      = '0;
    instr_ack  = 1'b0;
    wb_ack     = 1'b0;
    wb_stall   = 1'b0;
    seen       = 0;
    passed     = 0;
    failed     = 0;
    cycles     = 0;
    first_seen = 1'b0;
    $readmemh("dv/core_stim.txt", stim);
    n_prog = stim[0];
    n_st   = stim[1];
    limit  = 40 * n_prog + 20 * n_st;
    repeat (2) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;
    while (seen < n_st && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (seen < n_st) begin
      $display("timeout: only %0d of %0d stores after %0d cycles", seen, n_st, cycles);
      $display("tests: %0d passed, %0d failed", passed, failed);
      $display("=== FAIL ===");
    end else begin
      repeat (40) @(posedge clk);  // catch stray extra stores
      $display("tests: %0d passed, %0d failed", passed, failed);
      if (failed == 0)
        $display("=== PASS ===");
      else
        $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: logic/core.sv
`timescale 1ns/1ps

module core import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  output word_t     instr_addr,
  input  word_t     instr,
  output logic      instr_req,
  input  logic      instr_ack,
  output logic      wb_cyc,
  output logic      wb_stb,
  output word_t     wb_addr,
  output word_t     wb_wr_data,
  output byte_sel_t wb_wr_sel,
  input  logic      wb_ack,
  input  logic      wb_stall
);

  logic      stall;        // store port not idle
  logic      change_pc;    // redirect, also flushes fetch and decode
  word_t     next_pc;

  word_t     fetch_instr;
  word_t     fetch_pc;
  logic      fetch_valid;

  logic      dec_valid;
  word_t     dec_pc;
  word_t     dec_imm;
  word_t     dec_rs1_data;
  word_t     dec_rs2_data;
  reg_addr_t dec_rd;
  alu_op_e   dec_alu_op;
  opcode_e   dec_opcode;
  funct3_t   dec_funct3;

  logic      rd_wr_en;     // execute to register file
  reg_addr_t rd;
  word_t     rd_wr_data;

  logic      st_valid;     // execute to store port
  word_t     st_addr;
  word_t     st_data;
  funct3_t   st_funct3;

  fetch fetch0 (.*);

  decode decode0 (
    .*,
    .flush(change_pc)
  );

  execute execute0 (.*);

  store_unit store0 (
    .*,
    .busy(stall)
  );

endmodule

// File: logic/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath width of the integer core
`define CORE_XLEN 32

// x0..x31
`define CORE_REG_AW 5

// first fetch address after reset
`define CORE_PC_RESET 32'h0000_0000

// addi x0, x0, 0
// fills flushed or unknown slots in decode
`define CORE_NOP 32'h0000_0013

`endif

// File: logic/decode.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module decode import isa_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      stall,
  input  logic      flush,         // taken branch or jal in execute
  input  word_t     fetch_instr,
  input  word_t     fetch_pc,
  input  logic      fetch_valid,
  input  logic      rd_wr_en,      // write port, driven by execute
  input  reg_addr_t rd,
  input  word_t     rd_wr_data,
  output logic      dec_valid,
  output word_t     dec_pc,
  output word_t     dec_imm,
  output word_t     dec_rs1_data,
  output word_t     dec_rs2_data,
  output reg_addr_t dec_rd,
  output alu_op_e   dec_alu_op,
  output opcode_e   dec_opcode,
  output funct3_t   dec_funct3
);

  word_t     instr;
  logic      known;
  opcode_e   opcode;
  funct3_t   funct3;
  word_t     imm;
  alu_op_e   alu_op;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;

  always_comb begin
    case (fetch_instr[6:0])
      OP_IMM, OP: known = fetch_instr[14:12] != F3_SLTU;
      LUI, JAL:   known = 1'b1;
      BRANCH:     known = fetch_instr[14:12] inside {F3_BEQ, F3_BNE};
      STORE:      known = fetch_instr[14:12] inside {F3_SB, F3_SH, F3_SW};
      default:    known = 1'b0;
    endcase
  end

  // anything else retires as a nop
  assign instr  = (fetch_valid && known) ? fetch_instr : `CORE_NOP;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  always_comb begin
    case (opcode)
      STORE:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      BRANCH:  imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      LUI:     imm = {instr[31:12], 12'b0};
      JAL:     imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = {{20{instr[31]}}, instr[31:20]};  // I type
    endcase
  end

  always_comb begin
    alu_op = ALU_ADD;  // stores, jal and branches
    if (opcode == LUI)
      alu_op = ALU_PASS_B;
    else if (opcode == OP || opcode == OP_IMM) begin
      case (funct3)
        F3_ADD: alu_op = (opcode == OP && instr[30]) ? ALU_SUB : ALU_ADD;
        F3_SLL: alu_op = ALU_SLL;
        F3_SLT: alu_op = ALU_SLT;
        F3_XOR: alu_op = ALU_XOR;
        F3_SR:  alu_op = instr[30] ? ALU_SRA : ALU_SRL;  // same bit for srai
        F3_OR:  alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
    end
  end

  regs regs0 (
    .clk, .rst_n, .rs1, .rs2, .rd, .rd_wr_en, .rd_wr_data, .rs1_data, .rs2_data
  );

  always_ff @(posedge clk) begin
    if (!rst_n)
      dec_valid <= 1'b0;
    else if (flush)
      dec_valid <= 1'b0;  // wrong path slot
    else if (!stall)
      dec_valid <= fetch_valid;
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      dec_pc       <= fetch_pc;
      dec_imm      <= imm;
      dec_rs1_data <= rs1_data;
      dec_rs2_data <= rs2_data;
      dec_rd       <= instr[11:7];
      dec_alu_op   <= alu_op;
      dec_opcode   <= opcode;
      dec_funct3   <= funct3;
    end
  end

endmodule

// File: logic/execute.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module execute import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      stall,
  input  logic      dec_valid,
  input  word_t     dec_pc,
  input  word_t     dec_imm,
  input  word_t     dec_rs1_data,
  input  word_t     dec_rs2_data,
  input  reg_addr_t dec_rd,
  input  alu_op_e   dec_alu_op,
  input  opcode_e   dec_opcode,
  input  funct3_t   dec_funct3,
  output logic      rd_wr_en,
  output reg_addr_t rd,
  output word_t     rd_wr_data,
  output logic      change_pc,
  output word_t     next_pc,
  output logic      st_valid,
  output word_t     st_addr,
  output word_t     st_data,
  output funct3_t   st_funct3
);

  word_t   op_b;
  word_t   alu_res;
  word_t   link;                         // jal return address
  logic [$clog2(`CORE_XLEN)-1:0] shamt;
  logic    eq;
  pc_src_e pc_src;

  assign op_b  = (dec_opcode == OP) ? dec_rs2_data : dec_imm;
  assign shamt = op_b[$clog2(`CORE_XLEN)-1:0];
  assign link  = dec_pc + word_t'(4);
  assign eq    = dec_rs1_data == dec_rs2_data;

  always_comb begin
    case (dec_alu_op)
      ALU_ADD:    alu_res = dec_rs1_data + op_b;  // also store address
      ALU_SUB:    alu_res = dec_rs1_data - op_b;
      ALU_SLT:    alu_res = word_t'($signed(dec_rs1_data) < $signed(op_b));
      ALU_XOR:    alu_res = dec_rs1_data ^ op_b;
      ALU_OR:     alu_res = dec_rs1_data | op_b;
      ALU_AND:    alu_res = dec_rs1_data & op_b;
      ALU_SLL:    alu_res = dec_rs1_data << shamt;
      ALU_SRL:    alu_res = dec_rs1_data >> shamt;
      ALU_SRA:    alu_res = word_t'($signed(dec_rs1_data) >>> shamt);
      default:    alu_res = op_b;                  // lui
    endcase
  end

  // written at the edge closing this cycle, decode picks it up via the bypass
  assign rd_wr_en   = dec_valid && !stall && (dec_opcode inside {OP_IMM, OP, LUI, JAL});
  assign rd         = dec_rd;
  assign rd_wr_data = (dec_opcode == JAL) ? link : alu_res;

  always_comb begin
    pc_src = PC_SEQ;
    if (dec_valid) begin
      case (dec_opcode)
        JAL:    pc_src = PC_REDIRECT;
        // only beq/bne get here, bne taken when not equal
        BRANCH: pc_src = ((dec_funct3 == F3_BNE) != eq) ? PC_REDIRECT : PC_SEQ;
        default: pc_src = PC_SEQ;
      endcase
    end
  end

  assign change_pc = (pc_src == PC_REDIRECT) && !stall;
  assign next_pc   = dec_pc + dec_imm;  // same form for jal and branch

  always_ff @(posedge clk) begin
    if (!rst_n)
      st_valid <= 1'b0;
    else if (!stall)
      st_valid <= dec_valid && dec_opcode == STORE;
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      st_addr   <= alu_res;
      st_data   <= dec_rs2_data;
      st_funct3 <= dec_funct3;
    end
  end

endmodule

// File: logic/fetch.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module fetch import isa_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  stall,        // store port busy
  input  logic  change_pc,    // redirect from execute
  input  word_t next_pc,
  input  word_t instr,        // valid with instr_ack
  input  logic  instr_ack,
  output word_t instr_addr,
  output logic  instr_req,
  output word_t fetch_instr,
  output word_t fetch_pc,
  output logic  fetch_valid
);

  word_t pc;          // next address to request
  word_t pc_sel;
  logic  discard;     // outstanding answer is from the old path
  logic  req_hold;
  logic  take;
  logic  valid_next;
  logic  issue;

  assign pc_sel   = change_pc ? next_pc : pc;
  assign req_hold = instr_req && !instr_ack;  // keep addr stable until ack
  // ack lands in the output slot unless it belongs to a dropped path
  assign take     = instr_req && instr_ack && !discard && !change_pc;
  // one request at a time, only into an empty slot
  assign issue    = !req_hold && !stall && !valid_next;

  always_comb begin
    if (change_pc)
      valid_next = 1'b0;          // slot flushed
    else if (take)
      valid_next = 1'b1;
    else if (!stall)
      valid_next = 1'b0;          // consumed by decode
    else
      valid_next = fetch_valid;   // frozen
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc          <= `CORE_PC_RESET;
      instr_addr  <= `CORE_PC_RESET;
      instr_req   <= 1'b0;
      discard     <= 1'b0;
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= valid_next;
      instr_req   <= req_hold || issue;
      if (issue) begin
        instr_addr <= pc_sel;
        pc         <= pc_sel + word_t'(4);
      end else if (change_pc) begin
        pc <= next_pc;            // fetched once the old answer is back
      end
      if (change_pc)
        discard <= req_hold;
      else if (instr_ack)
        discard <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      fetch_instr <= instr;
      fetch_pc    <= instr_addr;
    end
  end

endmodule

// File: logic/isa_pkg.sv
`include "core_macros.svh"

package isa_pkg;

  typedef logic [`CORE_XLEN-1:0]   word_t;      // data, address or instruction
  typedef logic [`CORE_REG_AW-1:0] reg_addr_t;  // register index
  typedef logic [2:0]              funct3_t;

  // only the major opcodes this core executes
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111,
    BRANCH = 7'b1100011,
    STORE  = 7'b0100011
  } opcode_e;

  // alu funct3
  localparam funct3_t F3_ADD  = 3'b000;  // add/sub, addi
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;  // not implemented
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;  // srl/sra by bit 30
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // branch funct3
  localparam funct3_t F3_BEQ = 3'b000;
  localparam funct3_t F3_BNE = 3'b001;

  // store size
  localparam funct3_t F3_SB = 3'b000;
  localparam funct3_t F3_SH = 3'b001;
  localparam funct3_t F3_SW = 3'b010;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_XOR, ALU_OR,
    ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
  } alu_op_e;

endpackage

// File: logic/pipe_pkg.sv
`include "core_macros.svh"

package pipe_pkg;

  // one strobe per byte lane, bit 0 = lowest byte
  typedef logic [`CORE_XLEN/8-1:0] byte_sel_t;

  // store bus sequencer
  typedef enum logic [1:0] {IDLE, REQUEST, WAIT_ACK} store_state_e;

  // where the next pc comes from
  typedef enum logic {PC_SEQ, PC_REDIRECT} pc_src_e;

endpackage

// File: logic/regs.sv
`timescale 1ns/1ps

module regs import isa_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  logic      rd_wr_en,
  input  word_t     rd_wr_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t mem [1:31];  // no storage behind x0

  // x0 reads zero, same-cycle write passes straight through
  function automatic word_t read_port(input reg_addr_t sel);
    if (sel == '0)
      return '0;
    if (rd_wr_en && rd == sel)
      return rd_wr_data;  // bypass
    return mem[sel];
  endfunction

  always_ff @(posedge clk) begin
    if (rst_n && rd_wr_en && rd != '0)
      mem[rd] <= rd_wr_data;
  end

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

endmodule

// File: logic/store_unit.sv
`timescale 1ns/1ps

module store_unit import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      st_valid,
  input  word_t     st_addr,
  input  word_t     st_data,
  input  funct3_t   st_funct3,
  output logic      busy,        // global stall
  output logic      wb_cyc,
  output logic      wb_stb,
  output word_t     wb_addr,
  output word_t     wb_wr_data,
  output byte_sel_t wb_wr_sel,
  input  logic      wb_ack,
  input  logic      wb_stall
);

  store_state_e state;
  byte_sel_t    sel;
  word_t        lane_data;  // store data repeated over the lanes

  always_comb begin
    case (st_funct3)
      F3_SB: begin
        sel       = byte_sel_t'(1) << st_addr[1:0];
        lane_data = {4{st_data[7:0]}};
      end
      F3_SH: begin
        sel       = st_addr[1] ? byte_sel_t'(4'b1100) : byte_sel_t'(4'b0011);
        lane_data = {2{st_data[15:0]}};
      end
      default: begin  // sw
        sel       = '1;
        lane_data = st_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:
          if (st_valid) state <= REQUEST;
        REQUEST:
          if (!wb_stall) state <= wb_ack ? IDLE : WAIT_ACK;  // accepted
        WAIT_ACK:
          if (wb_ack) state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // bus fields frozen from capture to ack
  always_ff @(posedge clk) begin
    if (state == IDLE && st_valid) begin
      wb_addr    <= st_addr;
      wb_wr_data <= lane_data;
      wb_wr_sel  <= sel;
    end
  end

  assign wb_cyc = state != IDLE;
  assign wb_stb = state == REQUEST;
  assign busy   = wb_cyc;  // core frozen for the whole bus cycle

endmodule

// File: sources.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch.sv
logic/regs.sv
logic/decode.sv
logic/execute.sv
logic/store_unit.sv
logic/core.sv
dv/core_checker.sv
dv/core_tb.sv
